/* source/mm_host_defines.svh */
`ifndef MM_HOST_DEFINES_SVH
`define MM_HOST_DEFINES_SVH

// byte lanes per BRAM word
`define FM_LANES 8
`define WM_LANES 16

// control BRAM word indices
`define CTRL_FLAG_WORD 16'd0
`define CTRL_COM1_WORD 16'd1
`define CTRL_COM2_WORD 16'd2

// flag word codes shared with the accelerator
`define FLAG_START  32'd1
`define FLAG_FINISH 32'd2

`endif

/* source/mm_host_pkg.sv */
package mm_host_pkg;

    typedef logic [15:0] dim_t;
    typedef logic [15:0] count_t;
    typedef logic [15:0] bram_addr_t;
    typedef logic [63:0] fm_word_t; // 8 signed bytes
    typedef logic [127:0] wm_word_t; // 16 signed bytes
    typedef logic [31:0] ctrl_word_t;
    typedef logic signed [31:0] result_t;

    typedef enum logic [2:0] {
        IDLE,
        WRITE_FM,
        WRITE_WM,
        WRITE_COM,
        WRITE_FLAG,
        WAIT_FLAG,
        READ_OUT,
        FINISH
    } host_state_t;

endpackage

/* source/job_setup.sv */
`include "mm_host_defines.svh"

module job_setup (
    input  logic                arm_clk,
    input  logic                rst,
    input  logic                load_dims,
    input  mm_host_pkg::dim_t   m_in,
    input  mm_host_pkg::dim_t   n_in,
    input  mm_host_pkg::dim_t   p_in,
    output mm_host_pkg::dim_t   m,
    output mm_host_pkg::dim_t   n,
    output mm_host_pkg::dim_t   p,
    output mm_host_pkg::count_t fm_words,
    output mm_host_pkg::count_t wm_words,
    output mm_host_pkg::count_t out_words
);

    mm_host_pkg::count_t fm_cols; // feature words per column, m rounded up
    mm_host_pkg::count_t wm_cols; // weight words per row, p rounded up

    assign fm_cols = mm_host_pkg::count_t'((17'(m_in) + 17'(`FM_LANES - 1)) / 17'(`FM_LANES));
    assign wm_cols = mm_host_pkg::count_t'((17'(p_in) + 17'(`WM_LANES - 1)) / 17'(`WM_LANES));

    // counts are taken from the inputs so they are ready on the first phase cycle
    always_ff @(posedge arm_clk or posedge rst) begin
        if (rst) begin
            m         <= '0;
            n         <= '0;
            p         <= '0;
            fm_words  <= '0;
            wm_words  <= '0;
            out_words <= '0;
        end else if (load_dims) begin
            m         <= m_in;
            n         <= n_in;
            p         <= p_in;
            fm_words  <= mm_host_pkg::count_t'(n_in * fm_cols);
            wm_words  <= mm_host_pkg::count_t'(n_in * wm_cols);
            out_words <= mm_host_pkg::count_t'(m_in * p_in);
        end
    end

endmodule

/* source/host_fsm.sv */
`include "mm_host_defines.svh"

module host_fsm (
    input  logic                     arm_clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     fm_valid,
    input  logic                     wm_valid,
    input  mm_host_pkg::count_t      fm_words,
    input  mm_host_pkg::count_t      wm_words,
    input  mm_host_pkg::count_t      out_words,
    input  mm_host_pkg::ctrl_word_t  ctrl_dout,
    output mm_host_pkg::host_state_t state,
    output mm_host_pkg::count_t      count,
    output logic                     load_dims,
    output logic                     fm_phase,
    output logic                     wm_phase
);

    mm_host_pkg::host_state_t next_state;
    logic                     advance;   // counter steps this cycle
    logic                     last_word; // counter sits at the phase limit
    logic                     phase_end;
    logic                     poll_ready;
    logic                     finish_seen;

    // first two poll cycles still show command word or the old flag value
    assign poll_ready  = (count == 16'd2);
    assign finish_seen = (ctrl_dout == `FLAG_FINISH);

    always_comb begin
        advance   = 1'b0;
        last_word = 1'b0;
        case (state)
            mm_host_pkg::WRITE_FM: begin
                advance   = fm_valid;
                last_word = (count == fm_words - 16'd1);
            end
            mm_host_pkg::WRITE_WM: begin
                advance   = wm_valid;
                last_word = (count == wm_words - 16'd1);
            end
            mm_host_pkg::WRITE_COM: begin
                advance   = 1'b1;
                last_word = (count == 16'd1);
            end
            mm_host_pkg::WAIT_FLAG: begin
                advance   = !poll_ready || finish_seen;
                last_word = poll_ready && finish_seen;
            end
            mm_host_pkg::READ_OUT: begin
                advance   = 1'b1;
                last_word = (count == out_words - 16'd1);
            end
            default: ;
        endcase
    end

    assign phase_end = advance && last_word;
    assign load_dims = (state == mm_host_pkg::IDLE) && start;
    assign fm_phase  = (state == mm_host_pkg::WRITE_FM);
    assign wm_phase  = (state == mm_host_pkg::WRITE_WM);

    always_comb begin
        next_state = state;
        case (state)
            mm_host_pkg::IDLE:       if (start) next_state = mm_host_pkg::WRITE_FM;
            mm_host_pkg::WRITE_FM:   if (phase_end) next_state = mm_host_pkg::WRITE_WM;
            mm_host_pkg::WRITE_WM:   if (phase_end) next_state = mm_host_pkg::WRITE_COM;
            mm_host_pkg::WRITE_COM:  if (phase_end) next_state = mm_host_pkg::WRITE_FLAG;
            mm_host_pkg::WRITE_FLAG: next_state = mm_host_pkg::WAIT_FLAG;
            mm_host_pkg::WAIT_FLAG:  if (phase_end) next_state = mm_host_pkg::READ_OUT;
            mm_host_pkg::READ_OUT:   if (phase_end) next_state = mm_host_pkg::FINISH;
            default:                 next_state = mm_host_pkg::IDLE;
        endcase
    end

    always_ff @(posedge arm_clk or posedge rst) begin
        if (rst) begin
            state <= mm_host_pkg::IDLE;
            count <= '0;
        end else begin
            state <= next_state;
            if (advance) begin
                count <= last_word ? '0 : count + 16'd1; // wraps for the next phase
            end
        end
    end

endmodule

/* source/bram_write_driver.sv */
`include "mm_host_defines.svh"

module bram_write_driver (
    input  logic                     arm_clk,
    input  logic                     rst,
    input  logic                     fm_valid,
    input  logic                     wm_valid,
    input  mm_host_pkg::fm_word_t    fm_data,
    input  mm_host_pkg::wm_word_t    wm_data,
    input  mm_host_pkg::host_state_t state,
    input  mm_host_pkg::count_t      count,
    input  mm_host_pkg::dim_t        m,
    input  mm_host_pkg::dim_t        n,
    input  mm_host_pkg::dim_t        p,
    output logic                     fm_we,
    output logic                     wm_we,
    output logic                     ctrl_we,
    output mm_host_pkg::bram_addr_t  fm_addr,
    output mm_host_pkg::bram_addr_t  wm_addr,
    output mm_host_pkg::bram_addr_t  ctrl_addr,
    output mm_host_pkg::fm_word_t    fm_din,
    output mm_host_pkg::wm_word_t    wm_din,
    output mm_host_pkg::ctrl_word_t  ctrl_din
);

    logic fm_write;
    logic wm_write;

    assign fm_write = fm_valid && (state == mm_host_pkg::WRITE_FM);
    assign wm_write = wm_valid && (state == mm_host_pkg::WRITE_WM);

    always_ff @(posedge arm_clk or posedge rst) begin
        if (rst) begin
            fm_we   <= 1'b0;
            wm_we   <= 1'b0;
            ctrl_we <= 1'b0;
        end else begin
            fm_we   <= fm_write;
            wm_we   <= wm_write;
            ctrl_we <= (state == mm_host_pkg::WRITE_COM) || (state == mm_host_pkg::WRITE_FLAG);
        end
    end

    always_ff @(posedge arm_clk) begin
        if (fm_write) begin
            fm_addr <= count;
            fm_din  <= fm_data;
        end
        if (wm_write) begin
            wm_addr <= count;
            wm_din  <= wm_data;
        end
    end

    always_ff @(posedge arm_clk) begin
        case (state)
            mm_host_pkg::WRITE_COM: begin
                if (count == '0) begin
                    ctrl_addr <= `CTRL_COM1_WORD;
                    ctrl_din  <= {p, m};
                end else begin
                    ctrl_addr <= `CTRL_COM2_WORD;
                    ctrl_din  <= {16'd0, n};
                end
            end
            mm_host_pkg::WRITE_FLAG: begin
                ctrl_addr <= `CTRL_FLAG_WORD;
                ctrl_din  <= `FLAG_START;
            end
            mm_host_pkg::WAIT_FLAG: ctrl_addr <= `CTRL_FLAG_WORD; // poll address
            default: ;
        endcase
    end

endmodule

/* source/result_reader.sv */
module result_reader (
    input  logic                     arm_clk,
    input  logic                     rst,
    input  mm_host_pkg::host_state_t state,
    input  mm_host_pkg::count_t      count,
    input  mm_host_pkg::result_t     out_dout,
    output mm_host_pkg::bram_addr_t  out_addr,
    output logic                     result_valid,
    output logic                     done,
    output mm_host_pkg::result_t     result_data
);

    logic read_d1;   // address on the port this cycle
    logic finish_d1;

    always_ff @(posedge arm_clk or posedge rst) begin
        if (rst) begin
            read_d1      <= 1'b0;
            result_valid <= 1'b0;
            finish_d1    <= 1'b0;
            done         <= 1'b0;
        end else begin
            read_d1      <= (state == mm_host_pkg::READ_OUT);
            result_valid <= read_d1; // bram read latency
            finish_d1    <= (state == mm_host_pkg::FINISH);
            done         <= finish_d1; // lands after the last result
        end
    end

    always_ff @(posedge arm_clk) begin
        if (state == mm_host_pkg::READ_OUT) begin
            out_addr <= count;
        end
    end

    // read data is already aligned with result_valid
    assign result_data = out_dout;

endmodule

/* source/mm_host_top.sv */
module mm_host_top (
    input  logic                    arm_clk,
    input  logic                    rst,
    input  logic                    start,
    input  mm_host_pkg::dim_t       m_in,
    input  mm_host_pkg::dim_t       n_in,
    input  mm_host_pkg::dim_t       p_in,
    input  logic                    fm_valid,
    input  mm_host_pkg::fm_word_t   fm_data,
    input  logic                    wm_valid,
    input  mm_host_pkg::wm_word_t   wm_data,
    input  mm_host_pkg::ctrl_word_t ctrl_dout,
    input  mm_host_pkg::result_t    out_dout,
    output logic                    fm_phase,
    output logic                    wm_phase,
    output logic                    fm_we,
    output mm_host_pkg::bram_addr_t fm_addr,
    output mm_host_pkg::fm_word_t   fm_din,
    output logic                    wm_we,
    output mm_host_pkg::bram_addr_t wm_addr,
    output mm_host_pkg::wm_word_t   wm_din,
    output logic                    ctrl_we,
    output mm_host_pkg::bram_addr_t ctrl_addr,
    output mm_host_pkg::ctrl_word_t ctrl_din,
    output mm_host_pkg::bram_addr_t out_addr,
    output logic                    result_valid,
    output mm_host_pkg::result_t    result_data,
    output logic                    done
);

    mm_host_pkg::dim_t        m;
    mm_host_pkg::dim_t        n;
    mm_host_pkg::dim_t        p;
    mm_host_pkg::count_t      fm_words;
    mm_host_pkg::count_t      wm_words;
    mm_host_pkg::count_t      out_words;
    mm_host_pkg::host_state_t state;
    mm_host_pkg::count_t      count;
    logic                     load_dims;

    job_setup job_setup_inst (
        .arm_clk(arm_clk), .rst(rst), .load_dims(load_dims),
        .m_in(m_in), .n_in(n_in), .p_in(p_in),
        .m(m), .n(n), .p(p),
        .fm_words(fm_words), .wm_words(wm_words), .out_words(out_words)
    );

    host_fsm host_fsm_inst (
        .arm_clk(arm_clk), .rst(rst), .start(start),
        .fm_valid(fm_valid), .wm_valid(wm_valid),
        .fm_words(fm_words), .wm_words(wm_words), .out_words(out_words),
        .ctrl_dout(ctrl_dout), .state(state), .count(count),
        .load_dims(load_dims), .fm_phase(fm_phase), .wm_phase(wm_phase)
    );

    bram_write_driver bram_write_driver_inst (
        .arm_clk(arm_clk), .rst(rst),
        .fm_valid(fm_valid), .wm_valid(wm_valid),
        .fm_data(fm_data), .wm_data(wm_data),
        .state(state), .count(count), .m(m), .n(n), .p(p),
        .fm_we(fm_we), .wm_we(wm_we), .ctrl_we(ctrl_we),
        .fm_addr(fm_addr), .wm_addr(wm_addr), .ctrl_addr(ctrl_addr),
        .fm_din(fm_din), .wm_din(wm_din), .ctrl_din(ctrl_din)
    );

    result_reader result_reader_inst (
        .arm_clk(arm_clk), .rst(rst), .state(state), .count(count),
        .out_dout(out_dout), .out_addr(out_addr),
        .result_valid(result_valid), .done(done), .result_data(result_data)
    );

endmodule

/* testbench/mm_host_assertions.sv */
module mm_host_assertions (
    input logic arm_clk,
    input logic rst,
    input logic load_dims,
    input logic fm_we,
    input logic wm_we,
    input logic done,
    input logic result_valid
);

    int   failures = 0; // read by the testbench top at the end of the run
    logic in_job;       // from the start pulse up to done

    always_ff @(posedge arm_clk or posedge rst) begin
        if (rst) begin
            in_job <= 1'b0;
        end else if (load_dims) begin
            in_job <= 1'b1;
        end else if (done) begin
            in_job <= 1'b0;
        end
    end

    assert property (@(posedge arm_clk) disable iff (rst) !(fm_we && wm_we))
        else begin
            $error("feature and weight writes overlap");
            failures++;
        end

    assert property (@(posedge arm_clk) disable iff (rst) done |=> !done)
        else begin
            $error("done held for more than one cycle");
            failures++;
        end

    assert property (@(posedge arm_clk) disable iff (rst) $rose(result_valid) |-> in_job)
        else begin
            $error("result_valid rose outside a job");
            failures++;
        end

endmodule

bind mm_host_top mm_host_assertions mm_host_assertions_inst (.*);

/* testbench/mm_host_checker.sv */
`include "mm_host_defines.svh"

module mm_host_checker (
    input  logic                    arm_clk, rst, start, finished, acc_finished,
    input  mm_host_pkg::dim_t       m_in, n_in, p_in,
    input  mm_host_pkg::fm_word_t   fm_ref [0:63],
    input  mm_host_pkg::wm_word_t   wm_ref [0:63],
    input  logic                    fm_valid, wm_valid, fm_phase, wm_phase,
    input  logic                    fm_we, wm_we, ctrl_we, result_valid, done,
    input  mm_host_pkg::bram_addr_t fm_addr, wm_addr, ctrl_addr, out_addr,
    input  mm_host_pkg::fm_word_t   fm_din,
    input  mm_host_pkg::wm_word_t   wm_din,
    input  mm_host_pkg::ctrl_word_t ctrl_din,
    input  mm_host_pkg::result_t    result_data,
    output int                      errors
);

    int checks, jobs, job_errors;
    int fm_next, wm_next, ctrl_next, res_next;
    int fm_count, wm_count;
    int fm_acc, wm_acc; // words accepted in the current window
    bit in_job, fm_take, wm_take; // take: word accepted on this edge
    bit fm_win, wm_win; // expected phase levels
    mm_host_pkg::bram_addr_t out_addr_d;

    assign fm_count = int'(n_in) * ((int'(m_in) + `FM_LANES - 1) / `FM_LANES);
    assign wm_count = int'(n_in) * ((int'(p_in) + `WM_LANES - 1) / `WM_LANES);

    // element (row, col) of the product, unpacked from the stimulus words
    function automatic mm_host_pkg::result_t expected_result(input int idx);
        int row;
        int col;
        int fm_cols;
        int wm_cols;
        mm_host_pkg::result_t sum;
        row = idx / int'(p_in);
        col = idx % int'(p_in);
        fm_cols = (int'(m_in) + `FM_LANES - 1) / `FM_LANES;
        wm_cols = (int'(p_in) + `WM_LANES - 1) / `WM_LANES;
        sum = '0;
        for (int k = 0; k < int'(n_in); k++) begin
            sum += $signed(fm_ref[k * fm_cols + row / `FM_LANES][8 * (row % `FM_LANES) +: 8])
                 * $signed(wm_ref[k * wm_cols + col / `WM_LANES][8 * (col % `WM_LANES) +: 8]);
        end
        return sum;
    endfunction

    task automatic check_that(input bit ok, input string what);
        checks++;
        if (!ok) begin
            errors++;
            $display("[ERROR] %0t: %s", $time, what);
        end
    endtask

    always @(posedge arm_clk) begin
        if (rst) begin
            errors = 0;
            checks = 0;
            jobs = 0;
            in_job = 1'b0;
            fm_take = 1'b0;
            wm_take = 1'b0;
            fm_win = 1'b0;
            wm_win = 1'b0;
            fm_acc = 0;
            wm_acc = 0;
        end else begin
            check_that(fm_we == fm_take, "feature write does not follow fm_valid by one cycle");
            check_that(wm_we == wm_take, "weight write does not follow wm_valid by one cycle");
            check_that(fm_phase == fm_win && wm_phase == wm_win,
                "phase level does not match the write window");
            if (fm_we) begin
                check_that(fm_addr == 16'(fm_next) && fm_din == fm_ref[fm_next],
                    $sformatf("feature word %0d written as %h at %0d", fm_next, fm_din, fm_addr));
                fm_next++;
            end
            if (wm_we) begin
                check_that(wm_addr == 16'(wm_next) && wm_din == wm_ref[wm_next],
                    $sformatf("weight word %0d written as %h at %0d", wm_next, wm_din, wm_addr));
                wm_next++;
            end
            if (ctrl_we) begin
                case (ctrl_next)
                    0: check_that(ctrl_addr == `CTRL_COM1_WORD && ctrl_din == {p_in, m_in},
                        "first command word is wrong");
                    1: check_that(ctrl_addr == `CTRL_COM2_WORD && ctrl_din == {16'd0, n_in},
                        "second command word is wrong");
                    2: check_that(ctrl_addr == `CTRL_FLAG_WORD && ctrl_din == `FLAG_START,
                        "start flag write is wrong");
                    default: check_that(1'b0, "control write outside the command and flag phases");
                endcase
                ctrl_next++;
            end
            if (result_valid) begin
                if (res_next == 0) begin
                    check_that(acc_finished && ctrl_next == 3,
                        "readout started before the accelerator reported finish");
                end
                check_that(out_addr_d == 16'(res_next),
                    $sformatf("result %0d was read from address %0d", res_next, out_addr_d));
                check_that(result_data == expected_result(res_next),
                    $sformatf("result %0d is %0d, expected %0d",
                        res_next, result_data, expected_result(res_next)));
                res_next++;
            end
            if (!in_job) begin
                check_that(!(fm_we || wm_we || ctrl_we || result_valid || done
                    || fm_phase || wm_phase), "strobe or phase active outside a job");
            end
            if (done) begin
                check_that(res_next == int'(m_in) * int'(p_in) && fm_next == fm_count
                    && wm_next == wm_count && ctrl_next == 3, "job ended with missing or extra words");
                jobs++;
                $display("job %0d: M=%0d N=%0d P=%0d, %0d results, %0d errors",
                    jobs, m_in, n_in, p_in, res_next, errors - job_errors);
                in_job = 1'b0;
            end
            fm_take = fm_valid && fm_win;
            wm_take = wm_valid && wm_win;
            if (fm_take) begin
                fm_acc++;
                if (fm_acc == fm_count) begin
                    fm_win = 1'b0;
                    wm_win = 1'b1;
                end
            end
            if (wm_take) begin
                wm_acc++;
                if (wm_acc == wm_count) begin
                    wm_win = 1'b0;
                end
            end
            if (start && !in_job) begin
                in_job = 1'b1;
                job_errors = errors;
                fm_next = 0;
                wm_next = 0;
                ctrl_next = 0;
                res_next = 0;
                fm_acc = 0;
                wm_acc = 0;
                fm_win = 1'b1;
            end
            out_addr_d = out_addr;
        end
    end

    always @(posedge finished) begin
        $display("checks: %0d, errors: %0d, jobs: %0d", checks, errors, jobs);
    end

endmodule

/* testbench/tb_mm_host.sv */
`include "mm_host_defines.svh"

module tb_mm_host;

    logic                    arm_clk = 1'b0;
    logic                    rst, start, finished;
    mm_host_pkg::dim_t       m_in, n_in, p_in;
    logic                    fm_valid, wm_valid;
    mm_host_pkg::fm_word_t   fm_data;
    mm_host_pkg::wm_word_t   wm_data;
    mm_host_pkg::ctrl_word_t ctrl_dout = '0;
    mm_host_pkg::result_t    out_dout = '0;
    logic                    fm_phase, wm_phase, fm_we, wm_we, ctrl_we, result_valid, done;
    mm_host_pkg::bram_addr_t fm_addr, wm_addr, ctrl_addr, out_addr;
    mm_host_pkg::fm_word_t   fm_din;
    mm_host_pkg::wm_word_t   wm_din;
    mm_host_pkg::ctrl_word_t ctrl_din;
    mm_host_pkg::result_t    result_data;

    mm_host_pkg::fm_word_t   fm_ref [0:63]; // stimulus of the current job
    mm_host_pkg::wm_word_t   wm_ref [0:63];
    mm_host_pkg::fm_word_t   fm_mem [0:63];
    mm_host_pkg::wm_word_t   wm_mem [0:63];
    mm_host_pkg::ctrl_word_t ctrl_mem [0:3];
    mm_host_pkg::result_t    out_mem [0:511];
    mm_host_pkg::dim_t       job_dims [0:5][0:2]; // m, n, p per job
    logic                    acc_busy = 1'b0;
    logic                    acc_finished = 1'b0;
    int                      acc_wait = 0;
    int                      cycles = 0;
    int                      limit = 0;
    int                      errors;

    mm_host_top mm_host_top_inst (.*);
    mm_host_checker checker_inst (.*);

    always #2 arm_clk = ~arm_clk;

    always @(posedge arm_clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: no end of the run within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    // accelerator model, dimensions decoded from the command words
    task automatic compute_product();
        int dm;
        int dn;
        int dp;
        int fc;
        int wc;
        mm_host_pkg::result_t sum;
        dm = int'(ctrl_mem[1][15:0]);
        dp = int'(ctrl_mem[1][31:16]);
        dn = int'(ctrl_mem[2][15:0]);
        fc = (dm + `FM_LANES - 1) / `FM_LANES;
        wc = (dp + `WM_LANES - 1) / `WM_LANES;
        for (int i = 0; i < dm; i++) begin
            for (int k = 0; k < dp; k++) begin
                sum = '0;
                for (int j = 0; j < dn; j++) begin
                    sum += $signed(fm_mem[j * fc + i / `FM_LANES][8 * (i % `FM_LANES) +: 8])
                         * $signed(wm_mem[j * wc + k / `WM_LANES][8 * (k % `WM_LANES) +: 8]);
                end
                out_mem[i * dp + k] = sum;
            end
        end
    endtask

    // brams with one cycle registered reads, read before write
    always @(posedge arm_clk) begin
        if (fm_we) fm_mem[fm_addr[5:0]] <= fm_din;
        if (wm_we) wm_mem[wm_addr[5:0]] <= wm_din;
        if (ctrl_we) ctrl_mem[ctrl_addr[1:0]] <= ctrl_din;
        ctrl_dout <= ctrl_mem[ctrl_addr[1:0]];
        out_dout  <= out_mem[out_addr[8:0]];
        if (ctrl_we && ctrl_addr == `CTRL_FLAG_WORD && ctrl_din == `FLAG_START) begin
            acc_busy     <= 1'b1;
            acc_finished <= 1'b0;
            acc_wait     <= 5 + int'($urandom % 36);
        end else if (acc_busy) begin
            if (acc_wait == 0) begin
                compute_product();
                ctrl_mem[0]  <= `FLAG_FINISH;
                acc_busy     <= 1'b0;
                acc_finished <= 1'b1;
            end else begin
                acc_wait <= acc_wait - 1;
            end
        end
    end

    initial begin
        int fm_idx;
        int wm_idx;
        int fm_count;
        int wm_count;
        void'($urandom(32'hb813));
        rst = 1'b1;
        start = 1'b0;
        finished = 1'b0;
        fm_valid = 1'b0;
        wm_valid = 1'b0;
        fm_data = '0;
        wm_data = '0;
        m_in = '0;
        n_in = '0;
        p_in = '0;
        for (int j = 0; j < 6; j++) begin
            for (int d = 0; d < 3; d++) job_dims[j][d] = mm_host_pkg::dim_t'(1 + $urandom % 20);
            fm_count = int'(job_dims[j][1]) * ((int'(job_dims[j][0]) + 7) / 8);
            wm_count = int'(job_dims[j][1]) * ((int'(job_dims[j][2]) + 15) / 16);
            limit += 2 * (fm_count + wm_count + 40 + int'(job_dims[j][0] * job_dims[j][2]) + 20);
        end
        limit += 200;
        repeat (16) @(posedge arm_clk);
        @(negedge arm_clk);
        rst = 1'b0;
        for (int j = 0; j < 6; j++) begin
            @(negedge arm_clk); // dimensions change only once the last job's done is seen
            m_in = job_dims[j][0];
            n_in = job_dims[j][1];
            p_in = job_dims[j][2];
            fm_count = int'(n_in) * ((int'(m_in) + 7) / 8);
            wm_count = int'(n_in) * ((int'(p_in) + 15) / 16);
            for (int i = 0; i < fm_count; i++) fm_ref[i] = {$urandom, $urandom};
            for (int i = 0; i < wm_count; i++) wm_ref[i] = {$urandom, $urandom, $urandom, $urandom};
            start = 1'b1;
            fm_idx = 0;
            wm_idx = 0;
            do begin
                @(negedge arm_clk);
                start = 1'b0;
                fm_valid = fm_phase && ($urandom % 4 != 0); // drop about one cycle in four
                wm_valid = wm_phase && ($urandom % 4 != 0);
                if (fm_valid) begin
                    fm_data = fm_ref[fm_idx];
                    fm_idx++;
                end
                if (wm_valid) begin
                    wm_data = wm_ref[wm_idx];
                    wm_idx++;
                end
            end while (!done);
        end
        @(negedge arm_clk);
        finished = 1'b1;
        @(negedge arm_clk);
        if (errors == 0 && mm_host_top_inst.mm_host_assertions_inst.failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+source
source/mm_host_pkg.sv
source/job_setup.sv
source/host_fsm.sv
source/bram_write_driver.sv
source/result_reader.sv
source/mm_host_top.sv
testbench/mm_host_assertions.sv
testbench/mm_host_checker.sv
testbench/tb_mm_host.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_mm_host -f vlog.f
./obj_dir/Vtb_mm_host +verilator+error+limit+100 | tee sim.log
if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
